// ==== flist.f ====
+incdir+include
src/bank_isu_iq_pkg.sv
src/bank_isu_chan_pkg.sv
src/shift_priority_arb.sv
src/bank_isu_credit_manage.sv
src/bank_isu_enqueue.sv
src/bank_isu_queue.sv
src/bank_isu_top.sv
dv/bank_isu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the issue stage testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module bank_isu_tb -f flist.f \
  && ./obj_dir/Vbank_isu_tb > sim.log 2>&1 \
  || { echo "build or simulation run did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^Everything OK$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== dv/bank_isu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bank_isu_defs.svh"

module bank_isu_tb;

  import bank_isu_iq_pkg::*;
  import bank_isu_chan_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_TESTS  = 5;

  logic     clk;
  logic     rst;
  logic     req_valid;
  logic     req_ready;
  logic     req_is_read;
  ch_id_t   req_ch;
  iq_addr_t req_addr;
  logic     issue_valid;
  logic     issue_ready;
  logic     issue_is_read;
  ch_id_t   issue_ch;
  iq_addr_t issue_addr;
  iq_tag_t  issue_tag;
  ch_mask_t credit_release;

  int       seed = 32'hce1f5372;
  int       err_cnt = 0;
  int       err_start = 0;
  int       test_num = 1;
  int       acc_cnt = 0;    // accepted requests and thus the next expected tag
  int       iss_cnt = 0;
  int       cyc = 0;
  int       rdy_mode = 2;   // 0 random, 1 stalled, 2 always ready
  int       bp_acc = 0;     // requests accepted while the issue port is stalled
  bit       bp_on = 0;
  bit       sender_done;
  logic     sb_live [256] = '{default: 1'b0};
  logic     sb_rd   [256];
  ch_id_t   sb_ch   [256];
  iq_addr_t sb_addr [256];
  int       last_rd [4] = '{default: -1};  // newest read tag issued per channel
  int       outst   [4] = '{default: 0};   // reads issued and not yet released
  int       rd_iss  [4] = '{default: 0};
  int       due     [3][$]; // release times of issued reads
  bit       hold    [3];
  int       budget  [3];    // releases allowed through while a channel is held
  ch_mask_t rel_next = '0;

  bank_isu_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_is_read    (req_is_read),
    .req_ch         (req_ch),
    .req_addr       (req_addr),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_is_read  (issue_is_read),
    .issue_ch       (issue_ch),
    .issue_addr     (issue_addr),
    .issue_tag      (issue_tag),
    .credit_release (credit_release)
  );

  wire issue_fire = issue_valid & issue_ready;
  wire sb_match = sb_live[issue_tag] & (sb_rd[issue_tag] == issue_is_read)
                & (sb_ch[issue_tag] == issue_ch) & (sb_addr[issue_tag] == issue_addr);
  wire order_ok = ~issue_is_read | (int'(issue_tag) > last_rd[issue_ch]);

  task automatic note_error(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic note_problem(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  function automatic bit rand_bit();
    return ($random(seed) & 1) != 0;
  endfunction

  function automatic ch_id_t rand_ch();
    return ch_id_t'(($random(seed) & 32'h7fff) % 3);
  endfunction

  a_integrity: assert property (@(posedge clk) disable iff (rst) issue_fire |-> sb_match)
    else note_error("issued item is unknown, repeated or differs from its request");
  a_order: assert property (@(posedge clk) disable iff (rst) issue_fire |-> order_ok)
    else note_error("reads of one channel issued out of tag order");
  a_stable: assert property (@(posedge clk) disable iff (rst)
    issue_valid & ~issue_ready |=> issue_valid & $stable(issue_tag) & $stable(issue_addr)
                                   & $stable(issue_ch) & $stable(issue_is_read))
    else note_error("issue fields moved while the port was stalled");
  a_backpressure: assert property (@(posedge clk) disable iff (rst)
    bp_acc <= `BANK_ISU_DEPTH + 1)
    else note_error("too many requests accepted while the issue port was stalled");

  for (genvar c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin : g_credit
    a_credit: assert property (@(posedge clk) disable iff (rst)
      outst[c] <= `BANK_ISU_CREDIT_INIT)
      else note_error("a channel has more reads in flight than it has credits");
  end

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * 2000 * CLK_PERIOD);
    $display("run timed out, the testbench stopped waiting on the DUT");
    $display("Something failed");
    $finish;
  end

  // the scoreboard and the channel model update on each clock edge
  always @(posedge clk) begin
    ch_mask_t rel_v;
    bit       rd_now;
    if (!rst) begin
      cyc = cyc + 1;
      if (req_valid && req_ready) begin
        sb_live[iq_tag_t'(acc_cnt)] <= 1'b1;
        sb_rd[iq_tag_t'(acc_cnt)]   <= req_is_read;
        sb_ch[iq_tag_t'(acc_cnt)]   <= req_ch;
        sb_addr[iq_tag_t'(acc_cnt)] <= req_addr;
        acc_cnt <= acc_cnt + 1;
        if (bp_on) bp_acc <= bp_acc + 1;
      end
      if (issue_fire) begin
        sb_live[issue_tag] <= 1'b0;
        iss_cnt <= iss_cnt + 1;
        if (issue_is_read) begin
          last_rd[issue_ch] <= int'(issue_tag);
          due[issue_ch].push_back(cyc + 2 + (($random(seed) & 32'h7fff) % 9));
        end
      end
      for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
        rd_now = issue_fire & issue_is_read & (issue_ch == ch_id_t'(c));
        outst[c]  <= outst[c] + (rd_now ? 1 : 0) - (credit_release[c] ? 1 : 0);
        rd_iss[c] <= rd_iss[c] + (rd_now ? 1 : 0);
        rel_v[c] = 1'b0;
        if (due[c].size() > 0 && due[c][0] <= cyc && (!hold[c] || budget[c] > 0)) begin
          rel_v[c] = 1'b1;
          void'(due[c].pop_front());
          if (hold[c]) budget[c] = budget[c] - 1;
        end
      end
      rel_next <= rel_v;
    end
  end

  always @(posedge clk) begin
    #1;
    credit_release = rel_next;
    case (rdy_mode)
      0:       issue_ready = ($random(seed) & 3) != 0;
      1:       issue_ready = 1'b0;
      default: issue_ready = 1'b1;
    endcase
  end

  // called 1 ns after an edge, returns 1 ns after the edge that took the request
  task automatic send(input bit rd, input ch_id_t ch, input iq_addr_t addr);
    bit took;
    req_valid   = 1'b1;
    req_is_read = rd;
    req_ch      = ch;
    req_addr    = addr;
    do begin
      @(negedge clk);
      took = req_ready;
      @(posedge clk);
    end while (!took);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_issued(input int target, input int limit);
    int n;
    n = 0;
    while (iss_cnt < target && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (iss_cnt < target) note_problem("issue port stopped before all expected items left");
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((iss_cnt != acc_cnt || outst[0] + outst[1] + outst[2] != 0) && n < 500) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (n >= 500) note_problem("accepted requests never issued or credits never came back");
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s: %s", test_num, name, (err_cnt == err_start) ? "passed" : "failed");
    test_num++;
    err_start = err_cnt;
  endtask

  initial begin
    int base;
    rst = 1'b1;
    req_valid = 1'b0;
    req_is_read = 1'b0;
    req_ch = '0;
    req_addr = '0;
    issue_ready = 1'b0;
    credit_release = '0;
    sender_done = 1'b0;
    for (int c = 0; c < 3; c++) begin
      hold[c] = 1'b0;
      budget[c] = 0;
    end
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    assert (!issue_valid && req_ready) else note_error("DUT not idle right after reset");
    end_test("reset");
    @(posedge clk);
    #1;

    rdy_mode = 0;
    for (int i = 0; i < 60; i++) send(rand_bit(), rand_ch(), iq_addr_t'($random(seed)));
    drain();
    end_test("random traffic");

    // channel 1 keeps its releases, so only its first four reads may leave
    base = rd_iss[1];
    hold[1] = 1'b1;
    rdy_mode = 2;
    for (int i = 0; i < 6; i++) send(1'b1, 2'd1, iq_addr_t'($random(seed)));
    for (int i = 0; i < 6; i++) send(i < 2, (i % 2 == 0) ? 2'd0 : 2'd2, iq_addr_t'(i));
    wait_issued(acc_cnt - 2, 300);
    repeat (30) @(posedge clk);
    #1;
    assert (rd_iss[1] - base == `BANK_ISU_CREDIT_INIT && iss_cnt == acc_cnt - 2)
      else note_error("held channel issued a different number of reads than its credits");
    end_test("credit bound");

    for (int k = 1; k <= 2; k++) begin
      budget[1] = 1;
      wait_issued(acc_cnt - 2 + k, 100);
      repeat (20) @(posedge clk);
      #1;
      assert (rd_iss[1] - base == `BANK_ISU_CREDIT_INIT + k)
        else note_error("released credits did not unblock the same number of reads");
    end
    hold[1] = 1'b0;
    drain();
    end_test("release unblocks");

    rdy_mode = 1;
    issue_ready = 1'b0;
    bp_on = 1'b1;
    fork
      begin
        for (int i = 0; i < 12; i++) send(rand_bit(), rand_ch(), iq_addr_t'($random(seed)));
        sender_done = 1'b1;
      end
    join_none
    base = 0;
    while (req_ready && base < 100) begin
      @(posedge clk);
      #1;
      base++;
    end
    if (req_ready) note_problem("request port never pushed back with the issue port stalled");
    repeat (10) @(posedge clk);
    #1;
    bp_on = 1'b0;  // the stall ends here, later acceptances follow issues
    rdy_mode = 0;
    while (!sender_done) begin
      @(posedge clk);
      #1;
    end
    drain();
    end_test("back-pressure");

    $display("%0d tests, %0d accepted, %0d issued, %0d errors",
             test_num - 1, acc_cnt, iss_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/bank_isu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bank_isu_top (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              req_valid,
  output logic                             req_ready,
  input  wire                              req_is_read,
  input  wire bank_isu_chan_pkg::ch_id_t   req_ch,
  input  wire bank_isu_iq_pkg::iq_addr_t   req_addr,
  output logic                             issue_valid,
  input  wire                              issue_ready,
  output logic                             issue_is_read,
  output bank_isu_chan_pkg::ch_id_t        issue_ch,
  output bank_isu_iq_pkg::iq_addr_t        issue_addr,
  output bank_isu_iq_pkg::iq_tag_t         issue_tag,
  input  wire bank_isu_chan_pkg::ch_mask_t credit_release
);

  import bank_isu_iq_pkg::*;
  import bank_isu_chan_pkg::*;

  // intake stage to issue queue
  logic     enq_valid;
  logic     enq_ready;
  logic     enq_is_read;
  ch_id_t   enq_ch;
  iq_addr_t enq_addr;
  iq_tag_t  enq_tag;

  bank_isu_enqueue enqueue_i (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_is_read (req_is_read),
    .req_ch      (req_ch),
    .req_addr    (req_addr),
    .enq_valid   (enq_valid),
    .enq_ready   (enq_ready),
    .enq_is_read (enq_is_read),
    .enq_ch      (enq_ch),
    .enq_addr    (enq_addr),
    .enq_tag     (enq_tag)
  );

  bank_isu_queue queue_i (
    .clk            (clk),
    .rst            (rst),
    .enq_valid      (enq_valid),
    .enq_ready      (enq_ready),
    .enq_is_read    (enq_is_read),
    .enq_ch         (enq_ch),
    .enq_addr       (enq_addr),
    .enq_tag        (enq_tag),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_is_read  (issue_is_read),
    .issue_ch       (issue_ch),
    .issue_addr     (issue_addr),
    .issue_tag      (issue_tag),
    .credit_release (credit_release)
  );

endmodule

`default_nettype wire

// ==== src/bank_isu_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bank_isu_defs.svh"

module bank_isu_queue (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              enq_valid,
  output logic                             enq_ready,
  input  wire                              enq_is_read,
  input  wire bank_isu_chan_pkg::ch_id_t   enq_ch,
  input  wire bank_isu_iq_pkg::iq_addr_t   enq_addr,
  input  wire bank_isu_iq_pkg::iq_tag_t    enq_tag,
  output logic                             issue_valid,
  input  wire                              issue_ready,
  output logic                             issue_is_read,
  output bank_isu_chan_pkg::ch_id_t        issue_ch,
  output bank_isu_iq_pkg::iq_addr_t        issue_addr,
  output bank_isu_iq_pkg::iq_tag_t         issue_tag,
  input  wire bank_isu_chan_pkg::ch_mask_t credit_release
);

  import bank_isu_iq_pkg::*;
  import bank_isu_chan_pkg::*;

  logic     is_read_arr [`BANK_ISU_DEPTH];
  ch_id_t   ch_arr      [`BANK_ISU_DEPTH];
  iq_addr_t addr_arr    [`BANK_ISU_DEPTH];
  iq_tag_t  tag_arr     [`BANK_ISU_DEPTH];
  iq_mask_t valid_q;
  iq_mask_t allow;
  iq_mask_t ready_mask;
  iq_ptr_t  wr_ptr;
  iq_ptr_t  bot_ptr;   // oldest entry, may trail behind over freed slots
  iq_ptr_t  pick_ptr;
  iq_ptr_t  sel_ptr;
  iq_ptr_t  hold_ptr;
  logic     pick_found;
  logic     hold_q;    // an offered entry is waiting for issue_ready
  logic     enqueue;
  logic     dequeue;
  logic     bot_free;

  // when the write pointer has caught a trailing bottom pointer the ring
  // still holds entries, so writing there would put the newest at the bottom
  assign enq_ready = ~valid_q[wr_ptr] & ~((wr_ptr == bot_ptr) & (|valid_q));
  assign enqueue   = enq_valid & enq_ready;

  assign ready_mask = valid_q & allow;  // allow bits of empty slots are stale

  shift_priority_arb #(
    .WIDTH (`BANK_ISU_DEPTH)
  ) issue_arb_i (
    .valid  (ready_mask),
    .bottom (bot_ptr),
    .select (pick_ptr),
    .found  (pick_found)
  );

  assign sel_ptr       = hold_q ? hold_ptr : pick_ptr;
  assign issue_valid   = hold_q | pick_found;
  assign issue_is_read = is_read_arr[sel_ptr];
  assign issue_ch      = ch_arr[sel_ptr];
  assign issue_addr    = addr_arr[sel_ptr];
  assign issue_tag     = tag_arr[sel_ptr];
  assign dequeue       = issue_valid & issue_ready;

  // step over a freed slot, but an empty ring parks at the write pointer
  assign bot_free = ~valid_q[bot_ptr] & ((|valid_q) | (bot_ptr != wr_ptr));

  bank_isu_credit_manage credit_i (
    .clk                (clk),
    .rst                (rst),
    .enqueue            (enqueue),
    .write_ptr          (wr_ptr),
    .op_is_read         (enq_is_read),
    .ch                 (enq_ch),
    .bottom_ptr         (bot_ptr),
    .valid_array        (valid_q),
    .ch_id_array        (ch_arr),
    .credit_release     (credit_release),
    .credit_allow_array (allow)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
      wr_ptr  <= '0;
      bot_ptr <= '0;
      hold_q  <= 1'b0;
    end else begin
      if (enqueue) begin
        valid_q[wr_ptr] <= 1'b1;
        wr_ptr          <= wr_ptr + 1'b1;
      end
      if (dequeue) begin
        valid_q[sel_ptr] <= 1'b0;
      end
      if (bot_free) begin
        bot_ptr <= bot_ptr + 1'b1;
      end
      hold_q <= issue_valid & ~issue_ready;
    end
  end

  always_ff @(posedge clk) begin
    hold_ptr <= sel_ptr;  // keeps the offered slot fixed while stalled
    if (enqueue) begin
      is_read_arr[wr_ptr] <= enq_is_read;
      ch_arr[wr_ptr]      <= enq_ch;
      addr_arr[wr_ptr]    <= enq_addr;
      tag_arr[wr_ptr]     <= enq_tag;
    end
  end

endmodule

`default_nettype wire

// ==== src/bank_isu_enqueue.sv ====
`timescale 1ns/10ps
`default_nettype none

module bank_isu_enqueue (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             req_valid,
  output logic                            req_ready,
  input  wire                             req_is_read,
  input  wire bank_isu_chan_pkg::ch_id_t  req_ch,
  input  wire bank_isu_iq_pkg::iq_addr_t  req_addr,
  output logic                            enq_valid,
  input  wire                             enq_ready,
  output logic                            enq_is_read,
  output bank_isu_chan_pkg::ch_id_t       enq_ch,
  output bank_isu_iq_pkg::iq_addr_t       enq_addr,
  output bank_isu_iq_pkg::iq_tag_t        enq_tag
);

  import bank_isu_iq_pkg::*;

  logic    full_q;
  logic    accept;
  iq_tag_t tag_q;  // tag for the next accepted request

  // the stage refills in the same cycle it drains, so no bubble
  assign req_ready = ~full_q | enq_ready;
  assign accept    = req_valid & req_ready;
  assign enq_valid = full_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      full_q <= 1'b0;
      tag_q  <= '0;
    end else begin
      if (accept) begin
        full_q <= 1'b1;
        tag_q  <= tag_q + 1'b1;  // wraps after 255
      end else if (enq_ready) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      enq_is_read <= req_is_read;
      enq_ch      <= req_ch;
      enq_addr    <= req_addr;
      enq_tag     <= tag_q;
    end
  end

endmodule

`default_nettype wire

// ==== src/bank_isu_credit_manage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bank_isu_defs.svh"

module bank_isu_credit_manage (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              enqueue,
  input  wire bank_isu_iq_pkg::iq_ptr_t    write_ptr,
  input  wire                              op_is_read,
  input  wire bank_isu_chan_pkg::ch_id_t   ch,
  input  wire bank_isu_iq_pkg::iq_ptr_t    bottom_ptr,
  input  wire bank_isu_iq_pkg::iq_mask_t   valid_array,
  input  wire bank_isu_chan_pkg::ch_id_t   ch_id_array [`BANK_ISU_DEPTH],
  input  wire bank_isu_chan_pkg::ch_mask_t credit_release,
  output bank_isu_iq_pkg::iq_mask_t        credit_allow_array
);

  import bank_isu_iq_pkg::*;
  import bank_isu_chan_pkg::*;

  credit_cnt_t  credit_q  [`BANK_ISU_CHANNEL_NUM];
  credit_cnt_t  credit_d  [`BANK_ISU_CHANNEL_NUM];
  pending_cnt_t pend_q    [`BANK_ISU_CHANNEL_NUM];
  pending_cnt_t pend_d    [`BANK_ISU_CHANNEL_NUM];
  iq_mask_t     chan_wait [`BANK_ISU_CHANNEL_NUM];  // valid reads still without a credit
  iq_ptr_t      grant_ptr [`BANK_ISU_CHANNEL_NUM];
  ch_mask_t     has_credit;
  ch_mask_t     has_pend;
  ch_mask_t     enq_rd;       // incoming read targets this channel
  ch_mask_t     enq_direct;   // incoming read takes a credit right away
  ch_mask_t     grant;
  ch_mask_t     grant_found;
  ch_mask_t     alloc;
  iq_mask_t     allow_d;

  always_comb begin
    for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
      has_credit[c] = credit_q[c] != '0;
      has_pend[c]   = pend_q[c] != '0;
      enq_rd[c]     = enqueue & op_is_read & (ch == ch_id_t'(c));
      enq_direct[c] = enq_rd[c] & has_credit[c] & ~has_pend[c];
      for (int i = 0; i < `BANK_ISU_DEPTH; i++) begin
        chan_wait[c][i] = valid_array[i] & ~credit_allow_array[i]
                        & (ch_id_array[i] == ch_id_t'(c));
      end
    end
  end

  // oldest waiting read of each channel, searched from the queue bottom
  for (genvar c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin : g_chan_arb
    shift_priority_arb #(
      .WIDTH (`BANK_ISU_DEPTH)
    ) arb_i (
      .valid  (chan_wait[c]),
      .bottom (bottom_ptr),
      .select (grant_ptr[c]),
      .found  (grant_found[c])
    );
  end

  always_comb begin
    for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
      grant[c] = has_credit[c] & has_pend[c] & grant_found[c];
      alloc[c] = grant[c] | enq_direct[c];

      // a release and an allocation in one cycle cancel out
      case ({alloc[c], credit_release[c]})
        2'b10:   credit_d[c] = credit_q[c] - 1'b1;
        2'b01:   credit_d[c] = credit_q[c] + 1'b1;
        default: credit_d[c] = credit_q[c];
      endcase

      case ({enq_rd[c] & ~enq_direct[c], grant[c]})
        2'b10:   pend_d[c] = pend_q[c] + 1'b1;
        2'b01:   pend_d[c] = pend_q[c] - 1'b1;
        default: pend_d[c] = pend_q[c];
      endcase
    end
  end

  always_comb begin
    allow_d = credit_allow_array;
    if (enqueue) begin
      allow_d[write_ptr] = ~op_is_read | (|enq_direct);  // writes never wait
    end
    for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
      if (grant[c]) begin
        allow_d[grant_ptr[c]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      credit_allow_array <= '0;
      for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
        credit_q[c] <= credit_cnt_t'(`BANK_ISU_CREDIT_INIT);
        pend_q[c]   <= '0;
      end
    end else begin
      credit_allow_array <= allow_d;
      for (int c = 0; c < `BANK_ISU_CHANNEL_NUM; c++) begin
        credit_q[c] <= credit_d[c];
        pend_q[c]   <= pend_d[c];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/shift_priority_arb.sv ====
`timescale 1ns/10ps
`default_nettype none

module shift_priority_arb #(
  parameter int WIDTH = 8,
  localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  wire  [WIDTH-1:0] valid,
  input  wire  [IDX_W-1:0] bottom,
  output logic [IDX_W-1:0] select,
  output logic             found
);

  assign found = |valid;

  // walk the offsets from the far end back to zero so the smallest
  // offset from bottom is the one that sticks
  always_comb begin
    int idx;
    select = bottom;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      idx = int'(bottom) + i;
      if (idx >= WIDTH) begin
        idx = idx - WIDTH;  // wrap around the end of the ring
      end
      if (valid[idx]) begin
        select = IDX_W'(idx);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/bank_isu_chan_pkg.sv ====
`default_nettype none

`include "bank_isu_defs.svh"

package bank_isu_chan_pkg;

  typedef logic [1:0]                       ch_id_t;       // target channel number
  typedef logic [`BANK_ISU_CHANNEL_NUM-1:0] ch_mask_t;     // one bit per channel
  typedef logic [3:0]                       credit_cnt_t;  // free read credits
  // pending reads can reach the full queue depth, hence one extra bit
  typedef logic [`BANK_ISU_PTR_WIDTH:0]     pending_cnt_t;

endpackage

`default_nettype wire

// ==== src/bank_isu_iq_pkg.sv ====
`default_nettype none

`include "bank_isu_defs.svh"

package bank_isu_iq_pkg;

  typedef logic [`BANK_ISU_PTR_WIDTH-1:0]  iq_ptr_t;   // index of a queue slot
  typedef logic [`BANK_ISU_DEPTH-1:0]      iq_mask_t;  // one bit per queue slot

  // running sequence number stamped on every accepted request
  typedef logic [7:0]                      iq_tag_t;

  typedef logic [`BANK_ISU_ADDR_WIDTH-1:0] iq_addr_t;

endpackage

`default_nettype wire

// ==== include/bank_isu_defs.svh ====
`ifndef BANK_ISU_DEFS_SVH
`define BANK_ISU_DEFS_SVH

// number of memory channels served by the scheduler
`define BANK_ISU_CHANNEL_NUM 3

// the issue queue depth must stay a power of two
`define BANK_ISU_PTR_WIDTH 3
`define BANK_ISU_DEPTH     8

// read credits a channel holds after reset
`define BANK_ISU_CREDIT_INIT 4

// request address width
`define BANK_ISU_ADDR_WIDTH 16

`endif
